//--- compile.f
rtl/rv_pkg.sv
rtl/imem_bus_if.sv
rtl/imem_arbiter.sv
rtl/inst_mem.sv
rtl/reg_file.sv
rtl/alu.sv
rtl/control_fsm.sv
rtl/rv_core_top.sv
bench/rv_core_asserts.sv
bench/rv_core_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= rv_core_tb
OBJ_DIR ?= obj_dir
FILELIST ?= compile.f
VFLAGS ?= --binary --timing --assert

SRCS := $(wildcard rtl/*.sv bench/*.sv)
BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# pass only if the pass line shows up in the output
run: $(BIN)
	$(BIN) | awk '{ print } /^>>> PASS$$/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf $(OBJ_DIR)

//--- bench/rv_core_tb.sv
`timescale 1ns/1ns

module rv_core_tb import rv_pkg::*; ();

	// instructions executed over all runs, halts included
	localparam int TOTAL_INSTR = 15 + 11 + 5 + 21 + 3;
	localparam int CYCLE_LIMIT = TOTAL_INSTR * 6 + 200;

	logic clk;
	logic rst;
	logic start;
	logic done;
	logic prog_we;
	pc_t prog_addr;
	word_t prog_data;
	reg_addr_t dbg_addr;
	word_t dbg_data;

	// program under construction and the predicted register file
	word_t prog[$];
	word_t model [32];
	int errors;
	int checks;
	int busy_cycles;
	logic running;
	integer seed;

	rv_core_top rv_core_top_i (.clk(clk), .rst(rst), .start(start), .done(done),
		.prog_we(prog_we), .prog_addr(prog_addr), .prog_data(prog_data),
		.dbg_addr(dbg_addr), .dbg_data(dbg_data));

	bind control_fsm rv_core_asserts asserts_i (.clk(clk), .rst(rst), .state(state),
		.rd_we(rd_we), .done(done), .fetch_gnt(fetch_bus.gnt));

	// 8 ns clock
	always #4 clk = ~clk;

	// watchdog, counts only cycles while the core runs
	always @(posedge clk)
	begin
		if (running)
		begin
			busy_cycles <= busy_cycles + 1;
			if (busy_cycles > CYCLE_LIMIT)
			begin
				$display("timeout, core did not raise done within %0d cycles", CYCLE_LIMIT);
				$display(">>> FAIL");
				$finish;
			end
		end
	end

	// ------------------------------------------------------------------
	// RV32I reference semantics and encoders
	// ------------------------------------------------------------------
	function automatic word_t expected_result(input logic [2:0] f3, input logic alt,
		input word_t a, input word_t b);
		word_t r;
		logic [4:0] sh;
		sh = b[4:0];
		case (f3)
			3'b000: r = alt ? a - b : a + b;
			3'b001: r = a << sh;
			3'b010: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			3'b011: r = (a < b) ? 32'd1 : 32'd0;
			3'b100: r = a ^ b;
			3'b101: r = alt ? word_t'($signed(a) >>> sh) : a >> sh;
			3'b110: r = a | b;
			default: r = a & b;
		endcase
		return r;
	endfunction

	// register-register op, alt picks sub or sra
	task automatic emit_rr(input logic [2:0] f3, input logic alt, input int rd,
		input int rs1, input int rs2);
		word_t a;
		word_t b;
		a = model[rs1];
		b = model[rs2];
		prog.push_back({1'b0, alt, 5'b0, 5'(rs2), 5'(rs1), f3, 5'(rd), OPC_OP});
		if (rd != 0)
			model[rd] = expected_result(f3, alt, a, b);
	endtask

	// register-immediate op, srai carries its flag in imm bit 10
	task automatic emit_imm(input logic [2:0] f3, input int rd, input int rs1,
		input logic [11:0] imm);
		word_t b;
		logic alt;
		b = {{20{imm[11]}}, imm};
		alt = (f3 == F3_SRL_SRA) ? imm[10] : 1'b0;
		prog.push_back({imm, 5'(rs1), f3, 5'(rd), OPC_OP_IMM});
		if (rd != 0)
			model[rd] = expected_result(f3, alt, model[rs1], b);
	endtask

	task automatic emit_lui(input int rd, input logic [19:0] imm);
		prog.push_back({imm, 5'(rd), OPC_LUI});
		if (rd != 0)
			model[rd] = {imm, 12'b0};
	endtask

	// ------------------------------------------------------------------
	// loader, start and readback
	// ------------------------------------------------------------------
	task automatic load_program();
		prog.push_back('0);
		for (int i = 0; i < prog.size(); i++)
		begin
			@(posedge clk);
			#1;
			prog_we = 1'b1;
			prog_addr = pc_t'(i);
			prog_data = prog[i];
		end
		@(posedge clk);
		#1;
		prog_we = 1'b0;
	endtask

	task automatic run_program();
		load_program();
		@(posedge clk);
		#1;
		start = 1'b1;
		running = 1'b1;
		@(posedge clk);
		#1;
		start = 1'b0;
		checks++;
		if (done !== 1'b0)
		begin
			$display("ERROR %0t: done still high after start", $time);
			errors++;
		end
		// loader rewrites the halt word for a few cycles, first fetch has to wait
		prog_we = 1'b1;
		prog_addr = pc_t'(prog.size() - 1);
		prog_data = '0;
		repeat (3) @(posedge clk);
		#1;
		prog_we = 1'b0;
		// done comes from the halt on the all-zero word
		while (done !== 1'b1)
		begin
			@(posedge clk);
			#1;
		end
		running = 1'b0;
	endtask

	task automatic check_regs(input string tag);
		for (int i = 0; i < 32; i++)
		begin
			@(posedge clk);
			#1;
			dbg_addr = reg_addr_t'(i);
			#2;
			checks++;
			if (dbg_data !== model[i])
			begin
				$display("ERROR %0t: %s x%0d = %h, expected %h", $time, tag, i,
					dbg_data, model[i]);
				errors++;
			end
		end
	endtask

	// ------------------------------------------------------------------
	// directed tests
	// ------------------------------------------------------------------
	task automatic test_reset();
		checks++;
		if (done !== 1'b0)
		begin
			$display("ERROR %0t: done high after reset", $time);
			errors++;
		end
		check_regs("reset");
	endtask

	task automatic test_reg_reg();
		prog.delete();
		// operands, some negative
		emit_imm(F3_ADD_SUB, 1, 0, 12'hff9);
		emit_imm(F3_ADD_SUB, 2, 0, 12'd13);
		emit_imm(F3_ADD_SUB, 3, 0, 12'h800);
		emit_imm(F3_ADD_SUB, 4, 0, 12'd3);
		emit_rr(F3_ADD_SUB, 1'b0, 5, 1, 2);
		emit_rr(F3_ADD_SUB, 1'b1, 6, 1, 2);
		emit_rr(F3_AND, 1'b0, 7, 1, 3);
		emit_rr(F3_OR, 1'b0, 8, 2, 3);
		emit_rr(F3_XOR, 1'b0, 9, 1, 2);
		emit_rr(F3_SLL, 1'b0, 10, 2, 4);
		emit_rr(F3_SRL_SRA, 1'b0, 11, 1, 4);
		emit_rr(F3_SRL_SRA, 1'b1, 12, 1, 4);
		emit_rr(F3_SLT, 1'b0, 13, 1, 2);
		emit_rr(F3_SLTU, 1'b0, 14, 1, 2);
		run_program();
		check_regs("reg_reg");
	endtask

	task automatic test_imm();
		prog.delete();
		emit_imm(F3_SLT, 15, 1, 12'hffd);
		// -1 sign extends to all ones, so any small value is below it
		emit_imm(F3_SLTU, 16, 2, 12'hfff);
		emit_imm(F3_XOR, 17, 1, 12'h0f0);
		emit_imm(F3_OR, 18, 2, 12'h7ff);
		emit_imm(F3_AND, 19, 1, 12'hf0f);
		emit_imm(F3_SLL, 20, 2, 12'h005);
		emit_imm(F3_SRL_SRA, 21, 1, 12'h01c);
		emit_imm(F3_SRL_SRA, 22, 1, {7'b0100000, 5'd3});
		emit_lui(23, 20'hdead5);
		emit_lui(24, 20'h80000);
		run_program();
		check_regs("imm");
	endtask

	task automatic test_x0_unsupported();
		prog.delete();
		emit_imm(F3_ADD_SUB, 0, 0, 12'd55);
		emit_rr(F3_ADD_SUB, 1'b0, 0, 1, 2);
		// lw x5, 4(x2) is not supported, x5 must keep its nonzero value
		prog.push_back({12'h004, 5'd2, 3'b010, 5'd5, 7'b0000011});
		emit_imm(F3_ADD_SUB, 26, 0, 12'd99);
		run_program();
		check_regs("x0_unsupported");
	endtask

	task automatic test_random();
		word_t r;
		prog.delete();
		for (int i = 0; i < 20; i++)
		begin
			r = $random(seed);
			if (r[31])
				emit_rr(F3_ADD_SUB, 1'b0, int'(r[4:0]), int'(r[9:5]), int'(r[14:10]));
			else
				emit_imm(F3_ADD_SUB, int'(r[4:0]), int'(r[9:5]), r[26:15]);
		end
		run_program();
		check_regs("random");
	endtask

	task automatic test_restart();
		checks++;
		if (done !== 1'b1)
		begin
			$display("ERROR %0t: core not halted before restart", $time);
			errors++;
		end
		prog.delete();
		emit_imm(F3_ADD_SUB, 27, 0, 12'd321);
		emit_lui(28, 20'h12345);
		run_program();
		check_regs("restart");
	endtask

	initial
	begin
		clk = 1'b0;
		rst = 1'b0;
		start = 1'b0;
		prog_we = 1'b0;
		prog_addr = '0;
		prog_data = '0;
		dbg_addr = '0;
		errors = 0;
		checks = 0;
		busy_cycles = 0;
		running = 1'b0;
		seed = 32'hc1dbd268;
		for (int i = 0; i < 32; i++)
			model[i] = '0;
		// reset for two cycles
		repeat (2) @(posedge clk);
		#1;
		rst = 1'b1;
		test_reset();
		test_reg_reg();
		test_imm();
		test_x0_unsupported();
		test_random();
		test_restart();
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

//--- bench/rv_core_asserts.sv
`timescale 1ns/1ns

module rv_core_asserts import rv_pkg::*; (
	input logic clk,
	input logic rst,
	input ctrl_state_e state,
	input logic rd_we,
	input logic done,
	input logic fetch_gnt
);

	// ------------------------------------------------------------------
	// controller properties
	// ------------------------------------------------------------------

	// register write strobe only in writeback
	a_we_in_wb: assert property (@(posedge clk) disable iff (!rst)
		rd_we |-> state == st_writeback)
		else $error("rd_we high outside writeback");

	// done only while halted
	a_done_halted: assert property (@(posedge clk) disable iff (!rst)
		done |-> state == st_halted)
		else $error("done high outside halted");

	// no grant means fetch is held
	a_fetch_gnt: assert property (@(posedge clk) disable iff (!rst)
		(state == st_fetch && !fetch_gnt) |=> state == st_fetch)
		else $error("fetch left without a grant");

	// state must be a known legal encoding
	a_state_legal: assert property (@(posedge clk) disable iff (!rst)
		!$isunknown(state) && state inside {st_idle, st_fetch, st_fetch_wait,
		st_decode, st_read, st_execute, st_writeback, st_halted})
		else $error("controller state out of range");

endmodule

//--- rtl/rv_core_top.sv
`timescale 1ns/1ns

module rv_core_top import rv_pkg::*; (
	input logic clk,
	input logic rst,
	input logic start,
	output logic done,
	input logic prog_we,
	input pc_t prog_addr,
	input word_t prog_data,
	input reg_addr_t dbg_addr,
	output word_t dbg_data
);

	imem_bus_if load_bus ();
	imem_bus_if fetch_bus ();
	imem_bus_if mem_bus ();

	// register file and alu nets
	reg_addr_t rs1_addr;
	reg_addr_t rs2_addr;
	reg_addr_t rd_addr;
	word_t rs1_data;
	word_t rs2_data;
	word_t rd_data;
	logic rd_we;
	alu_op_e alu_op;
	word_t alu_a;
	word_t alu_b;
	word_t alu_y;

	// loader is write only, one strobe per word
	assign load_bus.req = prog_we;
	assign load_bus.we = prog_we;
	assign load_bus.addr = prog_addr;
	assign load_bus.wdata = prog_data;
	// memory accepts every cycle
	assign mem_bus.gnt = 1'b1;

	imem_arbiter imem_arbiter_i (.load_bus(load_bus), .fetch_bus(fetch_bus), .mem_bus(mem_bus));

	inst_mem inst_mem_i (.clk(clk), .mem_bus(mem_bus));

	reg_file reg_file_i (.clk(clk), .rst(rst), .rs1_addr(rs1_addr), .rs2_addr(rs2_addr),
		.rs1_data(rs1_data), .rs2_data(rs2_data), .rd_we(rd_we), .rd_addr(rd_addr),
		.rd_data(rd_data), .dbg_addr(dbg_addr), .dbg_data(dbg_data));

	alu alu_i (.op(alu_op), .a(alu_a), .b(alu_b), .y(alu_y));

	control_fsm control_fsm_i (.clk(clk), .rst(rst), .start(start), .done(done),
		.fetch_bus(fetch_bus), .rs1_addr(rs1_addr), .rs2_addr(rs2_addr),
		.rs1_data(rs1_data), .rs2_data(rs2_data), .rd_we(rd_we), .rd_addr(rd_addr),
		.rd_data(rd_data), .alu_op(alu_op), .alu_a(alu_a), .alu_b(alu_b), .alu_y(alu_y));

endmodule

//--- rtl/control_fsm.sv
`timescale 1ns/1ns

module control_fsm import rv_pkg::*; (
	input logic clk,
	input logic rst,
	input logic start,
	output logic done,
	imem_bus_if.master fetch_bus,
	output reg_addr_t rs1_addr,
	output reg_addr_t rs2_addr,
	input word_t rs1_data,
	input word_t rs2_data,
	output logic rd_we,
	output reg_addr_t rd_addr,
	output word_t rd_data,
	output alu_op_e alu_op,
	output word_t alu_a,
	output word_t alu_b,
	input word_t alu_y
);

	ctrl_state_e state;
	ctrl_state_e state_nxt;
	pc_t pc;
	word_t ir;

	// instruction fields
	logic [6:0] opcode;
	logic [2:0] funct3;
	logic f7_b5;
	word_t imm_i;
	word_t imm_u;

	// decode results, operands and alu result
	alu_op_e op_q;
	word_t imm_q;
	logic use_imm_q;
	logic valid_q;
	word_t a_q;
	word_t b_q;
	word_t res_q;

	// ------------------------------------------------------------------
	// field split
	// ------------------------------------------------------------------
	assign opcode = ir[6:0];
	assign funct3 = ir[14:12];
	// funct7 bit 5 separates sub from add and sra from srl
	assign f7_b5 = ir[30];
	assign imm_i = {{(XLEN-12){ir[31]}}, ir[31:20]};
	assign imm_u = {ir[31:12], 12'b0};

	assign rs1_addr = ir[19:15];
	assign rs2_addr = ir[24:20];
	assign rd_addr = ir[11:7];

	// opcode, funct3 and funct7 bit 5 to alu op
	function automatic alu_op_e decode_op(input logic [6:0] opc, input logic [2:0] f3,
		input logic alt);
		alu_op_e op;
		op = alu_add;
		if (opc == OPC_LUI)
			op = alu_pass_b;
		else
			case (f3)
				// addi has no subtract form
				F3_ADD_SUB: op = (opc == OPC_OP && alt) ? alu_sub : alu_add;
				F3_SLL: op = alu_sll;
				F3_SLT: op = alu_slt;
				F3_SLTU: op = alu_sltu;
				F3_XOR: op = alu_xor;
				F3_SRL_SRA: op = alt ? alu_sra : alu_srl;
				F3_OR: op = alu_or;
				F3_AND: op = alu_and;
			endcase
		return op;
	endfunction

	// ------------------------------------------------------------------
	// state machine
	// ------------------------------------------------------------------
	always_comb
	begin
		state_nxt = state;
		case (state)
			st_idle, st_halted:
				if (start)
					state_nxt = st_fetch;
			// stall here while the loader owns the memory
			st_fetch:
				if (fetch_bus.gnt)
					state_nxt = st_fetch_wait;
			// all-zero word stops the core
			st_fetch_wait:
				state_nxt = (fetch_bus.rdata == '0) ? st_halted : st_decode;
			st_decode:
				state_nxt = st_read;
			st_read:
				state_nxt = st_execute;
			st_execute:
				state_nxt = st_writeback;
			st_writeback:
				state_nxt = st_fetch;
			default:
				state_nxt = st_idle;
		endcase
	end

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			state <= st_idle;
			pc <= '0;
			done <= 1'b0;
		end
		else
		begin
			state <= state_nxt;
			if ((state == st_idle || state == st_halted) && start)
			begin
				// restart from word 0
				pc <= '0;
				done <= 1'b0;
			end
			else if (state == st_fetch_wait && state_nxt == st_halted)
				done <= 1'b1;
			else if (state == st_writeback)
				pc <= pc + pc_t'(1);
		end
	end

	// ------------------------------------------------------------------
	// datapath registers, loaded one stage at a time
	// ------------------------------------------------------------------
	always_ff @(posedge clk)
	begin
		case (state)
			st_fetch_wait:
				ir <= fetch_bus.rdata;
			st_decode:
			begin
				op_q <= decode_op(opcode, funct3, f7_b5);
				use_imm_q <= (opcode != OPC_OP);
				imm_q <= (opcode == OPC_LUI) ? imm_u : imm_i;
				// anything else retires without writeback
				valid_q <= (opcode == OPC_OP) || (opcode == OPC_OP_IMM) || (opcode == OPC_LUI);
			end
			st_read:
			begin
				a_q <= rs1_data;
				b_q <= use_imm_q ? imm_q : rs2_data;
			end
			st_execute:
				res_q <= alu_y;
			default:
			begin
			end
		endcase
	end

	// fetch is read only
	assign fetch_bus.req = (state == st_fetch);
	assign fetch_bus.we = 1'b0;
	assign fetch_bus.addr = pc;
	assign fetch_bus.wdata = '0;

	assign alu_op = op_q;
	assign alu_a = a_q;
	assign alu_b = b_q;

	// single write pulse in writeback
	assign rd_we = (state == st_writeback) && valid_q;
	assign rd_data = res_q;

endmodule

//--- rtl/alu.sv
`timescale 1ns/1ns

module alu import rv_pkg::*; (
	input alu_op_e op,
	input word_t a,
	input word_t b,
	output word_t y
);

	// shift amount is the low five bits of b for both reg and imm forms
	logic [4:0] shamt;
	logic lt_signed;
	logic lt_unsigned;

	assign shamt = b[4:0];
	assign lt_signed = $signed(a) < $signed(b);
	assign lt_unsigned = a < b;

	always_comb
	begin
		case (op)
			alu_add:
				y = a + b;
			alu_sub:
				y = a - b;
			alu_sll:
				y = a << shamt;
			// set-less-than results are zero extended
			alu_slt:
				y = {{(XLEN-1){1'b0}}, lt_signed};
			alu_sltu:
				y = {{(XLEN-1){1'b0}}, lt_unsigned};
			alu_xor:
				y = a ^ b;
			alu_srl:
				y = a >> shamt;
			// arithmetic shift keeps the sign bit
			alu_sra:
				y = $signed(a) >>> shamt;
			alu_or:
				y = a | b;
			alu_and:
				y = a & b;
			// lui, b already holds the upper immediate
			alu_pass_b:
				y = b;
			default:
				y = '0;
		endcase
	end

endmodule

//--- rtl/reg_file.sv
`timescale 1ns/1ns

module reg_file import rv_pkg::*; (
	input logic clk,
	input logic rst,
	input reg_addr_t rs1_addr,
	input reg_addr_t rs2_addr,
	output word_t rs1_data,
	output word_t rs2_data,
	input logic rd_we,
	input reg_addr_t rd_addr,
	input word_t rd_data,
	input reg_addr_t dbg_addr,
	output word_t dbg_data
);

	// x1 .. x31, x0 has no storage
	word_t regs [1:31];

	// write port, index zero dropped
	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			for (int i = 1; i < 32; i++)
				regs[i] <= '0;
		end
		else if (rd_we && rd_addr != '0)
		begin
			regs[rd_addr] <= rd_data;
		end
	end

	// combinational reads, x0 forced to zero
	assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
	assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];
	// debug port for observing the file from outside
	assign dbg_data = (dbg_addr == '0) ? '0 : regs[dbg_addr];

endmodule

//--- rtl/inst_mem.sv
`timescale 1ns/1ns

module inst_mem import rv_pkg::*; (
	input logic clk,
	imem_bus_if.mem mem_bus
);

	// single port word array
	word_t ram [IMEM_DEPTH];

	// write or registered read, one access per cycle
	always_ff @(posedge clk)
	begin
		if (mem_bus.req)
		begin
			if (mem_bus.we)
				ram[mem_bus.addr] <= mem_bus.wdata;
			else
				// rdata holds its value over writes and idle cycles
				mem_bus.rdata <= ram[mem_bus.addr];
		end
	end

endmodule

//--- rtl/imem_arbiter.sv
`timescale 1ns/1ns

module imem_arbiter import rv_pkg::*; (
	imem_bus_if.arb load_bus,
	imem_bus_if.arb fetch_bus,
	imem_bus_if.master mem_bus
);

	// loader has fixed priority over fetch
	logic load_sel;
	pc_t sel_addr;
	word_t sel_wdata;

	assign load_sel = load_bus.req;

	// request path toward the memory
	assign sel_addr = load_sel ? load_bus.addr : fetch_bus.addr;
	assign sel_wdata = load_sel ? load_bus.wdata : fetch_bus.wdata;

	assign mem_bus.req = load_bus.req | fetch_bus.req;
	assign mem_bus.we = load_sel ? load_bus.we : fetch_bus.we;
	assign mem_bus.addr = sel_addr;
	assign mem_bus.wdata = sel_wdata;

	// grants, fetch only when the loader is quiet
	assign load_bus.gnt = load_bus.req & mem_bus.gnt;
	assign fetch_bus.gnt = fetch_bus.req & ~load_bus.req & mem_bus.gnt;

	// read data goes back to both peers, only the reader looks at it
	assign load_bus.rdata = mem_bus.rdata;
	assign fetch_bus.rdata = mem_bus.rdata;

endmodule

//--- rtl/imem_bus_if.sv
`timescale 1ns/1ns

interface imem_bus_if import rv_pkg::*; ();
	// req is a plain strobe, held until gnt is seen
	logic req;
	logic gnt;
	logic we;
	pc_t addr;
	word_t wdata;
	// valid one cycle after a granted read
	word_t rdata;

	// requester side
	modport master (output req, output we, output addr, output wdata, input gnt, input rdata);
	// arbiter side facing a requester
	modport arb (input req, input we, input addr, input wdata, output gnt, output rdata);
	// memory side, memory never stalls so it has no gnt
	modport mem (input req, input we, input addr, input wdata, output rdata);

endinterface

//--- rtl/rv_pkg.sv
package rv_pkg;

	// ------------------------------------------------------------------
	// widths and basic types
	// ------------------------------------------------------------------
	localparam int XLEN = 32;
	localparam int REG_ADDR_W = 5;
	// instruction memory is word addressed
	localparam int PC_W = 8;
	localparam int IMEM_DEPTH = 1 << PC_W;

	typedef logic [XLEN-1:0] word_t;
	typedef logic [REG_ADDR_W-1:0] reg_addr_t;
	typedef logic [PC_W-1:0] pc_t;

	// ------------------------------------------------------------------
	// opcodes and funct3 codes of the supported subset
	// ------------------------------------------------------------------
	localparam logic [6:0] OPC_OP = 7'b0110011;
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
	localparam logic [6:0] OPC_LUI = 7'b0110111;

	localparam logic [2:0] F3_ADD_SUB = 3'b000;
	localparam logic [2:0] F3_SLL = 3'b001;
	localparam logic [2:0] F3_SLT = 3'b010;
	localparam logic [2:0] F3_SLTU = 3'b011;
	localparam logic [2:0] F3_XOR = 3'b100;
	localparam logic [2:0] F3_SRL_SRA = 3'b101;
	localparam logic [2:0] F3_OR = 3'b110;
	localparam logic [2:0] F3_AND = 3'b111;

	// alu operation, pass_b serves lui
	typedef enum logic [3:0] {
		alu_add, alu_sub, alu_sll, alu_slt, alu_sltu, alu_xor,
		alu_srl, alu_sra, alu_or, alu_and, alu_pass_b
	} alu_op_e;

	// controller state, one instruction walks fetch .. writeback
	typedef enum logic [2:0] {
		st_idle, st_fetch, st_fetch_wait, st_decode,
		st_read, st_execute, st_writeback, st_halted
	} ctrl_state_e;

endpackage
